// File: spi_pkg.sv
`default_nettype none

package spi_pkg;

    // --------------------------------------------------
    // widths with a meaning on the spi command port.
    // --------------------------------------------------
    typedef logic [15:0] spi_word_t;   // one word per cs frame.
    typedef logic [31:0] mem_addr_t;   // sent as low word, then high word.
    typedef logic [7:0]  io_addr_t;
    typedef logic [7:0]  cmd_code_t;   // upper byte of a command word.

    // --------------------------------------------------
    // command codes.
    // --------------------------------------------------
    localparam cmd_code_t CMD_IO_READ   = 8'h80;
    localparam cmd_code_t CMD_MEM_READ  = 8'hC0;
    localparam cmd_code_t CMD_MEM_WRITE = 8'hC1;
    localparam cmd_code_t CMD_CORE_RUN  = 8'h10;

    // identification words at io addresses 0 to 3.
    localparam spi_word_t ID_WORD_0 = 16'h1234;
    localparam spi_word_t ID_WORD_1 = 16'h5678;
    localparam spi_word_t ID_WORD_2 = 16'h9ABC;
    localparam spi_word_t ID_WORD_3 = 16'hEF01;

    localparam io_addr_t IO_MEM_DATA = 8'h04;   // memory data register.

    localparam int DEFAULT_RAM_ADDR_W = 10;

endpackage

`default_nettype wire

// File: spi_frame_port.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_port (
    input  logic              clk_50MHz,
    input  logic              reset,
    input  logic              spi_sck_i,
    input  logic              spi_cs_i,
    input  logic              spi_mosi_i,
    input  spi_pkg::spi_word_t tx_word_i,
    output logic              spi_miso_o,
    output spi_pkg::spi_word_t rx_word_o,
    output logic              rx_valid_o
);

    import spi_pkg::*;

    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_q;
    logic       cs_q;

    logic       sck_rise;
    logic       sck_fall;
    logic       cs_fall;

    logic [3:0] bit_cnt;
    spi_word_t  rx_shift;
    spi_word_t  tx_shift;

    // --------------------------------------------------
    // pin synchronizers and edge detection.
    // --------------------------------------------------
    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            sck_sync  <= 2'b00;
            cs_sync   <= 2'b11;   // cs idles high.
            mosi_sync <= 2'b00;
            sck_q     <= 1'b0;
            cs_q      <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            cs_sync   <= {cs_sync[0], spi_cs_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sck_q     <= sck_sync[1];
            cs_q      <= cs_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_q;
    assign sck_fall = ~sck_sync[1] & sck_q;
    assign cs_fall  = cs_q & ~cs_sync[1];

    // --------------------------------------------------
    // bit counter, response shifter and word strobe.
    // --------------------------------------------------
    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            bit_cnt    <= '0;
            tx_shift   <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (cs_fall) begin
                bit_cnt  <= '0;
                tx_shift <= tx_word_i;   // response is fixed at frame start.
            end else if (!cs_sync[1]) begin
                if (sck_rise) begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd15) begin
                        rx_valid_o <= 1'b1;
                    end
                end
                if (sck_fall) begin
                    tx_shift <= {tx_shift[14:0], 1'b0};   // mode 0, change on fall.
                end
            end
        end
    end

    // receive shifter, msb first.
    always_ff @(posedge clk_50MHz) begin
        if (!cs_sync[1] && sck_rise) begin
            rx_shift <= {rx_shift[14:0], mosi_sync[1]};
        end
    end

    assign rx_word_o  = rx_shift;   // stable until the next frame's first edge.
    assign spi_miso_o = tx_shift[15];

    // one strobe per frame, never stretched.
    assert property (@(posedge clk_50MHz) disable iff (reset)
        rx_valid_o |=> !rx_valid_o);

endmodule

`default_nettype wire

// File: spi_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_fsm #(
    parameter int ram_addr_w = 10
) (
    input  logic                  clk_50MHz,
    input  logic                  reset,
    input  spi_pkg::spi_word_t    rx_word_i,
    input  logic                  rx_valid_i,
    output spi_pkg::io_addr_t     io_addr_o,
    output logic                  io_addr_load_o,
    output spi_pkg::spi_word_t    data_o,
    output logic                  data_load_o,
    output logic [ram_addr_w-1:0] ram_addr_o,
    output spi_pkg::spi_word_t    ram_wdata_o,
    output logic                  ram_we_o,
    output logic                  ram_re_o,
    input  spi_pkg::spi_word_t    ram_rdata_i,
    output logic                  core_run_o
);

    import spi_pkg::*;

    typedef enum logic [2:0] {
        state_idle,
        state_io_read,
        state_addr_lo,
        state_addr_hi,
        state_data_lo,
        state_mem_write,
        state_mem_read,
        state_mem_read_wait
    } state_t;

    state_t    state;
    state_t    ret_state;   // taken after the address high word.
    cmd_code_t cmd;
    mem_addr_t addr_q;
    spi_word_t wdata_q;

    assign cmd = rx_word_i[15:8];

    // --------------------------------------------------
    // state sequencing.
    // --------------------------------------------------
    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            state          <= state_idle;
            ret_state      <= state_idle;
            io_addr_load_o <= 1'b0;
            core_run_o     <= 1'b0;
        end else begin
            io_addr_load_o <= 1'b0;
            case (state)
                state_idle: begin
                    if (rx_valid_i) begin
                        case (cmd)
                            CMD_IO_READ: begin
                                io_addr_load_o <= 1'b1;
                                state          <= state_io_read;
                            end
                            CMD_MEM_READ: begin
                                ret_state <= state_mem_read;
                                state     <= state_addr_lo;
                            end
                            CMD_MEM_WRITE: begin
                                ret_state <= state_data_lo;
                                state     <= state_addr_lo;
                            end
                            CMD_CORE_RUN: core_run_o <= rx_word_i[0];
                            default: ;   // unknown commands are ignored.
                        endcase
                    end
                end
                state_io_read: begin
                    if (rx_valid_i) begin   // dummy word.
                        state <= state_idle;
                    end
                end
                state_addr_lo: begin
                    if (rx_valid_i) begin
                        state <= state_addr_hi;
                    end
                end
                state_addr_hi: begin
                    if (rx_valid_i) begin
                        state <= ret_state;
                    end
                end
                state_data_lo: begin
                    if (rx_valid_i) begin
                        state <= state_mem_write;
                    end
                end
                state_mem_write:     state <= state_idle;
                state_mem_read:      state <= state_mem_read_wait;
                state_mem_read_wait: state <= state_idle;
                default:             state <= state_idle;
            endcase
        end
    end

    // --------------------------------------------------
    // address, data and io address capture.
    // --------------------------------------------------
    always_ff @(posedge clk_50MHz) begin
        if (rx_valid_i) begin
            case (state)
                state_idle:    io_addr_o      <= rx_word_i[7:0];
                state_addr_lo: addr_q[15:0]   <= rx_word_i;
                state_addr_hi: addr_q[31:16]  <= rx_word_i;
                state_data_lo: wdata_q        <= rx_word_i;
                default: ;
            endcase
        end
    end

    // only the low bits reach the ram so higher addresses alias.
    assign ram_addr_o  = addr_q[ram_addr_w-1:0];
    assign ram_wdata_o = wdata_q;
    assign ram_we_o    = (state == state_mem_write);
    assign ram_re_o    = (state == state_mem_read);

    // read data is valid the cycle after the read strobe.
    assign data_load_o = (state == state_mem_write) || (state == state_mem_read_wait);
    assign data_o      = (state == state_mem_read_wait) ? ram_rdata_i : wdata_q;

    // no word may arrive while a memory access is still running.
    assert property (@(posedge clk_50MHz) disable iff (reset)
        rx_valid_i |-> !(state inside {state_mem_write, state_mem_read,
                                       state_mem_read_wait}));

endmodule

`default_nettype wire

// File: word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int ram_addr_w = 10
) (
    input  logic                  clk_50MHz,
    input  logic [ram_addr_w-1:0] addr_i,
    input  spi_pkg::spi_word_t    wdata_i,
    input  logic                  we_i,
    input  logic                  re_i,
    output spi_pkg::spi_word_t    rdata_o
);

    import spi_pkg::*;

    localparam int ram_depth = 2 ** ram_addr_w;

    spi_word_t mem [0:ram_depth-1];

    // single port, write and read share the address.
    always_ff @(posedge clk_50MHz) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[addr_i];   // registered read.
        end
    end

endmodule

`default_nettype wire

// File: readback_select.sv
`timescale 1ns/1ps
`default_nettype none

module readback_select (
    input  logic               clk_50MHz,
    input  logic               reset,
    input  spi_pkg::io_addr_t  io_addr_i,
    input  logic               io_addr_load_i,
    input  spi_pkg::spi_word_t data_i,
    input  logic               data_load_i,
    output spi_pkg::spi_word_t tx_word_o
);

    import spi_pkg::*;

    io_addr_t  io_addr_q;
    spi_word_t data_q;
    spi_word_t next_word;
    logic      update_q;

    always_comb begin
        case (io_addr_q)
            8'h00:       next_word = ID_WORD_0;
            8'h01:       next_word = ID_WORD_1;
            8'h02:       next_word = ID_WORD_2;
            8'h03:       next_word = ID_WORD_3;
            IO_MEM_DATA: next_word = data_q;
            default:     next_word = '0;
        endcase
    end

    // the response word follows the registers one cycle after any load,
    // and holds zero after reset until the first command.
    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            io_addr_q <= '0;
            data_q    <= '0;
            update_q  <= 1'b0;
            tx_word_o <= '0;
        end else begin
            update_q <= io_addr_load_i | data_load_i;
            if (io_addr_load_i) begin
                io_addr_q <= io_addr_i;
            end
            if (data_load_i) begin
                data_q <= data_i;
            end
            if (update_q) begin
                tx_word_o <= next_word;
            end
        end
    end

    assert property (@(posedge clk_50MHz) disable iff (reset)
        !(io_addr_load_i && data_load_i));

endmodule

`default_nettype wire

// File: spi_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module spi_mem_bridge #(
    parameter int ram_addr_w = spi_pkg::DEFAULT_RAM_ADDR_W
) (
    input  logic clk_50MHz,
    input  logic reset,
    input  logic spi_sck_i,
    input  logic spi_cs_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o,
    output logic core_run_o
);

    import spi_pkg::*;

    spi_word_t             rx_word;
    logic                  rx_valid;
    spi_word_t             tx_word;
    io_addr_t              io_addr;
    logic                  io_addr_load;
    spi_word_t             data;
    logic                  data_load;
    logic [ram_addr_w-1:0] ram_addr;
    spi_word_t             ram_wdata;
    spi_word_t             ram_rdata;
    logic                  ram_we;
    logic                  ram_re;

    spi_frame_port spi_frame_port_inst (
        .clk_50MHz  (clk_50MHz),
        .reset      (reset),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_i   (spi_cs_i),
        .spi_mosi_i (spi_mosi_i),
        .tx_word_i  (tx_word),
        .spi_miso_o (spi_miso_o),
        .rx_word_o  (rx_word),
        .rx_valid_o (rx_valid)
    );

    spi_cmd_fsm #(
        .ram_addr_w (ram_addr_w)
    ) spi_cmd_fsm_inst (
        .clk_50MHz      (clk_50MHz),
        .reset          (reset),
        .rx_word_i      (rx_word),
        .rx_valid_i     (rx_valid),
        .io_addr_o      (io_addr),
        .io_addr_load_o (io_addr_load),
        .data_o         (data),
        .data_load_o    (data_load),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_we_o       (ram_we),
        .ram_re_o       (ram_re),
        .ram_rdata_i    (ram_rdata),
        .core_run_o     (core_run_o)
    );

    word_ram #(
        .ram_addr_w (ram_addr_w)
    ) word_ram_inst (
        .clk_50MHz (clk_50MHz),
        .addr_i    (ram_addr),
        .wdata_i   (ram_wdata),
        .we_i      (ram_we),
        .re_i      (ram_re),
        .rdata_o   (ram_rdata)
    );

    readback_select readback_select_inst (
        .clk_50MHz      (clk_50MHz),
        .reset          (reset),
        .io_addr_i      (io_addr),
        .io_addr_load_i (io_addr_load),
        .data_i         (data),
        .data_load_i    (data_load),
        .tx_word_o      (tx_word)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period_ns = 10,   // 20 ns period, 50 MHz.
    parameter int reset_cycles   = 2
) (
    output logic clk_50MHz,
    output logic reset
);

    initial begin
        clk_50MHz = 1'b0;
        forever #(half_period_ns) clk_50MHz = ~clk_50MHz;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk_50MHz);
        reset <= 1'b0;   // released on a rising edge.
    end

endmodule

`default_nettype wire

// File: tb_spi_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_mem_bridge;

    localparam int SCK_HALF       = 5;    // clk cycles per sck half-period.
    localparam int FRAME_GAP      = 20;   // clk cycles with cs high after a frame.
    localparam int TIMEOUT_MARGIN = 200;  // covers reset and start-up.
    localparam int FRAME_CYCLES   = 33 * SCK_HALF + FRAME_GAP + 1;
    localparam int MAX_STEPS      = 64;
    localparam int unsigned RAND_SEED = 32'h861c_2273;

    logic        clk_50MHz;
    logic        reset;
    logic        spi_sck;
    logic        spi_cs;
    logic        spi_mosi;
    logic        spi_miso;
    logic        core_run;

    logic [15:0] step_mem [0:3*MAX_STEPS-1];   // kind, word, expected per step.
    int          step_count;
    int          error_count;
    int          cycle_count = 0;
    int          cycle_limit = 32'h7fff_ffff;

    tb_clock_gen tb_clock_gen_inst (
        .clk_50MHz (clk_50MHz),
        .reset     (reset)
    );

    spi_mem_bridge #(
        .ram_addr_w (10)
    ) spi_mem_bridge_inst (
        .clk_50MHz  (clk_50MHz),
        .reset      (reset),
        .spi_sck_i  (spi_sck),
        .spi_cs_i   (spi_cs),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .core_run_o (core_run)
    );

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_50MHz);
    endtask

    // --------------------------------------------------
    // one mode 0 frame, msb first.
    // --------------------------------------------------
    task automatic spi_transfer(input logic [15:0] word, output logic [15:0] resp);
        @(posedge clk_50MHz);
        spi_cs   <= 1'b0;
        spi_mosi <= word[15];
        for (int i = 15; i >= 0; i--) begin
            wait_cycles(SCK_HALF);
            resp[i] = spi_miso;   // settled since the last falling sck.
            spi_sck <= 1'b1;
            wait_cycles(SCK_HALF);
            spi_sck <= 1'b0;
            if (i > 0) begin
                spi_mosi <= word[i-1];
            end
        end
        wait_cycles(SCK_HALF);
        spi_cs <= 1'b1;
        wait_cycles(FRAME_GAP);
    endtask

    // run limit.
    always @(posedge clk_50MHz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not end within %0d clock cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [15:0] word;
        logic [15:0] expect_val;
        logic [15:0] resp;
        int unsigned rand_val;

        spi_sck     <= 1'b0;
        spi_cs      <= 1'b1;
        spi_mosi    <= 1'b0;
        error_count = 0;
        rand_val    = $urandom(RAND_SEED);

        // unused entries read as kind 0xf..., which ends the step list.
        for (int j = 0; j < 3 * MAX_STEPS; j++) begin
            step_mem[j] = {4'hf, j[11:0]};
        end
        $readmemh("testdata.hex", step_mem);
        step_count = 0;
        while (step_count < MAX_STEPS && step_mem[3*step_count] <= 16'd2) begin
            step_count++;
        end
        cycle_limit = step_count * FRAME_CYCLES * 2 + TIMEOUT_MARGIN;

        wait_cycles(1);
        while (reset) begin
            wait_cycles(1);
        end
        wait_cycles(2);

        for (int s = 0; s < step_count; s++) begin
            word       = step_mem[3*s+1];
            expect_val = step_mem[3*s+2];
            if (step_mem[3*s] == 16'd2) begin
                if (core_run !== expect_val[0]) begin
                    error_count++;
                    $display("CHECK FAILED: core_run_o step %0d expected %h got %h",
                             s, expect_val[0], core_run);
                end
            end else begin
                if (word == 16'hffff) begin   // dummy word.
                    rand_val = $urandom();
                    word     = rand_val[15:0];
                end
                spi_transfer(word, resp);
                if (step_mem[3*s] == 16'd1 && resp !== expect_val) begin
                    error_count++;
                    $display("CHECK FAILED: spi_miso_o step %0d expected %h got %h",
                             s, expect_val, resp);
                end
            end
        end

        $display("steps run: %0d, errors: %0d", step_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testdata.hex
// columns: kind (0 frame, 1 frame with response check, 2 core_run_o check),
// word to send (ffff sends a random dummy), expected response or level.
2 0000 0000
1 0000 0000
0 8000 0000
0 ffff 0000
1 8001 1234
0 ffff 0000
1 8002 5678
0 ffff 0000
1 8003 9abc
0 ffff 0000
1 8007 ef01
0 ffff 0000
1 c100 0000
0 0010 0000
0 0000 0000
0 a5c3 0000
0 8004 0000
0 ffff 0000
1 c100 a5c3
0 0123 0000
0 0000 0000
0 1357 0000
0 c000 0000
0 0010 0000
0 0000 0000
0 8004 0000
0 ffff 0000
1 c000 a5c3
0 0123 0000
0 0000 0000
0 8004 0000
0 ffff 0000
1 c000 1357
0 0410 0000
0 0001 0000
0 8004 0000
0 ffff 0000
1 1001 a5c3
2 0000 0001
0 1000 0000
2 0000 0000
0 9012 0000
1 0000 a5c3
0 8004 0000
0 ffff 0000
1 0000 a5c3

// File: list.f
spi_pkg.sv
spi_frame_port.sv
spi_cmd_fsm.sv
word_ram.sv
readback_select.sv
spi_mem_bridge.sv
tb_clock_gen.sv
tb_spi_mem_bridge.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_spi_mem_bridge \
    --Mdir obj_dir -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
